//--- src/fm_mix_pkg.sv
// Shared widths, slot counts and index types for the FM mixing stage
// Imported by every mixer module that needs them

package fm_mix_pkg;

    // Operator engine output width
    localparam int op_w = 14;
    // Sound output and ADPCM sample width
    localparam int snd_w = 16;
    // Minimum headroom above the input width in the accumulators
    localparam int acc_guard = 3;

    // Four operators per FM channel
    localparam int num_ops = 4;
    // Six channels times four operators
    localparam int slots_per_frame = 24;

    // Channel code, 3 and 7 never used
    typedef logic [2:0] ch_t;
    // Operator index, 0 is the first slot
    typedef logic [1:0] op_t;
    // FM algorithm 0..7
    typedef logic [2:0] alg_t;

    // First operator slot of these channels carries ADPCM
    localparam ch_t adpcma_ch = 3'd2;
    localparam ch_t adpcmb_ch = 3'd6;

endpackage

//--- src/fm_slot_counter.sv
// Slot sequencer for the mixer: operator outer loop, channel inner loop
// Produces one-hot operator flags and the frame start pulse
`timescale 1ns/100ps

module fm_slot_counter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clk_en,
    output fm_mix_pkg::ch_t   cur_ch,
    output fm_mix_pkg::op_t   cur_op,
    output logic              s1_enters,
    output logic              s2_enters,
    output logic              s3_enters,
    output logic              s4_enters,
    output logic              zero
);
    import fm_mix_pkg::*;

    ch_t next_ch;
    logic ch_wrap;

    // Channel order 0,1,2,4,5,6 then back to 0
    always_comb begin
        ch_wrap = 1'b0;
        case (cur_ch)
            3'd2:    next_ch = 3'd4;
            3'd6: begin
                next_ch = 3'd0;
                ch_wrap = 1'b1;
            end
            default: next_ch = cur_ch + 3'd1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_ch <= '0;
            cur_op <= '0;
        end else if (clk_en) begin
            cur_ch <= next_ch;
            // Operator steps once per channel sweep
            if (ch_wrap) begin
                cur_op <= (cur_op == op_t'(num_ops - 1)) ? op_t'(0) : cur_op + op_t'(1);
            end
        end
    end

    // Flag for operator cur_op + 1
    assign s1_enters = (cur_op == 2'd0);
    assign s2_enters = (cur_op == 2'd1);
    assign s3_enters = (cur_op == 2'd2);
    assign s4_enters = (cur_op == 2'd3);

    // Frame starts at op0 ch0
    assign zero = (cur_op == 2'd0) && (cur_ch == 3'd0);

    // Unused channel codes never reached
    a_no_gap_ch: assert property (@(posedge clk) disable iff (!rst_n)
        cur_ch != 3'd3 && cur_ch != 3'd7);

    // Operator index only moves when leaving channel 6
    a_op_step: assert property (@(posedge clk) disable iff (!rst_n)
        (clk_en && cur_ch != 3'd6) |=> (cur_op == $past(cur_op)));

endmodule

//--- src/fm_single_acc.sv
// Saturating frame accumulator; restarts and publishes on each frame pulse
// One instance per output side
`timescale 1ns/100ps

module fm_single_acc #(
    parameter int win  = fm_mix_pkg::snd_w,
    parameter int wout = fm_mix_pkg::snd_w
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_en,
    input  logic signed [win-1:0]  op_result,
    input  logic                   sum_en,
    input  logic                   zero,
    output logic signed [wout-1:0] snd
);
    import fm_mix_pkg::*;

    // Headroom for a whole frame of full-scale inputs
    localparam int frame_bits = $clog2(slots_per_frame);
    localparam int grow = (frame_bits > acc_guard) ? frame_bits : acc_guard;
    localparam int wacc = win + grow;

    // Signed wout limits, widened to the accumulator
    localparam logic signed [wacc-1:0] sat_max =
        {{(wacc - wout + 1){1'b0}}, {(wout - 1){1'b1}}};
    localparam logic signed [wacc-1:0] sat_min =
        {{(wacc - wout + 1){1'b1}}, {(wout - 1){1'b0}}};

    logic signed [wacc-1:0] acc;
    logic signed [wacc-1:0] in_ext;
    logic signed [wout-1:0] acc_sat;

    assign in_ext = {{(wacc - win){op_result[win-1]}}, op_result};

    // Clamp running total into output range
    always_comb begin
        if (acc > sat_max) begin
            acc_sat = sat_max[wout-1:0];
        end else if (acc < sat_min) begin
            acc_sat = sat_min[wout-1:0];
        end else begin
            acc_sat = acc[wout-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
            snd <= '0;
        end else if (clk_en) begin
            if (zero) begin
                // Publish last frame, first slot of new frame starts the sum
                snd <= acc_sat;
                acc <= sum_en ? in_ext : '0;
            end else if (sum_en) begin
                acc <= acc + in_ext;
            end
        end
    end

    // Overflowed frame lands exactly on the matching limit
    a_clamp_limit: assert property (@(posedge clk) disable iff (!rst_n)
        (clk_en && zero && (acc > sat_max || acc < sat_min))
        |=> (snd == sat_max[wout-1:0] || snd == sat_min[wout-1:0])
            && (snd[wout-1] == $past(acc[wacc-1])));

endmodule

//--- src/fm_mix_router.sv
// Picks carrier operators by algorithm, routes to left/right by rl
// Swaps in ADPCM-A and ADPCM-B samples on their reserved slots
`timescale 1ns/100ps

module fm_mix_router #(
    parameter int op_width  = fm_mix_pkg::op_w,
    parameter int snd_width = fm_mix_pkg::snd_w
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clk_en,
    input  logic                        zero,
    input  logic                        s1_enters,
    input  logic                        s2_enters,
    input  logic                        s3_enters,
    input  logic                        s4_enters,
    input  fm_mix_pkg::ch_t             cur_ch,
    input  fm_mix_pkg::op_t             cur_op,
    input  fm_mix_pkg::alg_t            alg,
    input  logic [1:0]                  rl,
    input  logic signed [op_width-1:0]  op_result,
    input  logic signed [snd_width-1:0] adpcma_l,
    input  logic signed [snd_width-1:0] adpcma_r,
    input  logic signed [snd_width-1:0] adpcmb_l,
    input  logic signed [snd_width-1:0] adpcmb_r,
    output logic signed [snd_width-1:0] left,
    output logic signed [snd_width-1:0] right
);
    import fm_mix_pkg::*;

    logic sum_en;
    logic signed [snd_width-1:0] op_ext;
    logic signed [snd_width-1:0] acc_in_l;
    logic signed [snd_width-1:0] acc_in_r;
    logic acc_en_l;
    logic acc_en_r;
    logic is_adpcma;
    logic is_adpcmb;

    // Carrier set per algorithm
    always_comb begin
        case (alg)
            3'd4:       sum_en = s2_enters | s4_enters;
            3'd5, 3'd6: sum_en = s2_enters | s3_enters | s4_enters;
            3'd7:       sum_en = 1'b1;
            default:    sum_en = s4_enters;
        endcase
    end

    // Operator result widened to sound width
    assign op_ext = {{(snd_width - op_width){op_result[op_width-1]}}, op_result};

    assign is_adpcma = (cur_op == op_t'(0)) && (cur_ch == adpcma_ch);
    assign is_adpcmb = (cur_op == op_t'(0)) && (cur_ch == adpcmb_ch);

    // ADPCM slots drop FM data and ignore alg/rl
    always_comb begin
        if (is_adpcma) begin
            acc_in_l = adpcma_l;
            acc_in_r = adpcma_r;
            acc_en_l = 1'b1;
            acc_en_r = 1'b1;
        end else if (is_adpcmb) begin
            acc_in_l = adpcmb_l;
            acc_in_r = adpcmb_r;
            acc_en_l = 1'b1;
            acc_en_r = 1'b1;
        end else begin
            acc_in_l = op_ext;
            acc_in_r = op_ext;
            // rl[1] left, rl[0] right
            acc_en_l = sum_en & rl[1];
            acc_en_r = sum_en & rl[0];
        end
    end

    fm_single_acc #(.win(snd_width), .wout(snd_width)) u_left (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .op_result (acc_in_l),
        .sum_en    (acc_en_l),
        .zero      (zero),
        .snd       (left)
    );

    fm_single_acc #(.win(snd_width), .wout(snd_width)) u_right (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .op_result (acc_in_r),
        .sum_en    (acc_en_r),
        .zero      (zero),
        .snd       (right)
    );

    // Counter's first-operator flag on an ADPCM channel forces both sides on
    a_adpcm_en: assert property (@(posedge clk) disable iff (!rst_n)
        (s1_enters && (cur_ch == adpcma_ch || cur_ch == adpcmb_ch))
        |-> (acc_en_l && acc_en_r));

endmodule

//--- src/fm_mix_top.sv
// Mixer top level: slot counter driving the carrier router and accumulators
// Slot indices and frame pulse exported so the operator source can follow
`timescale 1ns/100ps

module fm_mix_top #(
    parameter int op_width  = fm_mix_pkg::op_w,
    parameter int snd_width = fm_mix_pkg::snd_w
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clk_en,
    input  logic signed [op_width-1:0]  op_result,
    input  fm_mix_pkg::alg_t            alg,
    input  logic [1:0]                  rl,
    input  logic signed [snd_width-1:0] adpcma_l,
    input  logic signed [snd_width-1:0] adpcma_r,
    input  logic signed [snd_width-1:0] adpcmb_l,
    input  logic signed [snd_width-1:0] adpcmb_r,
    output fm_mix_pkg::ch_t             cur_ch,
    output fm_mix_pkg::op_t             cur_op,
    output logic                        zero,
    output logic signed [snd_width-1:0] left,
    output logic signed [snd_width-1:0] right
);

    // One-hot operator flags
    logic s1_enters;
    logic s2_enters;
    logic s3_enters;
    logic s4_enters;

    fm_slot_counter u_slot_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .cur_ch    (cur_ch),
        .cur_op    (cur_op),
        .s1_enters (s1_enters),
        .s2_enters (s2_enters),
        .s3_enters (s3_enters),
        .s4_enters (s4_enters),
        .zero      (zero)
    );

    fm_mix_router #(.op_width(op_width), .snd_width(snd_width)) u_router (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .zero      (zero),
        .s1_enters (s1_enters),
        .s2_enters (s2_enters),
        .s3_enters (s3_enters),
        .s4_enters (s4_enters),
        .cur_ch    (cur_ch),
        .cur_op    (cur_op),
        .alg       (alg),
        .rl        (rl),
        .op_result (op_result),
        .adpcma_l  (adpcma_l),
        .adpcma_r  (adpcma_r),
        .adpcmb_l  (adpcmb_l),
        .adpcmb_r  (adpcmb_r),
        .left      (left),
        .right     (right)
    );

endmodule

//--- testbench/tb_clock_gen.sv
// Free-running clock for the mixer testbench
// Period is twice half_period in ns
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int half_period = 10
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(half_period) clk = ~clk;

endmodule

//--- testbench/fm_mix_tb.sv
// Testbench for fm_mix_top: stands in for the operator engine, one table row per frame
// A reference model builds each frame's expected left/right sums
`timescale 1ns/100ps

module fm_mix_tb;
    import fm_mix_pkg::*;

    localparam int n_rows = 8;

    logic clk;
    logic rst_n;
    logic clk_en;
    logic signed [op_w-1:0] op_result;
    alg_t alg;
    logic [1:0] rl;
    logic signed [snd_w-1:0] adpcma_l;
    logic signed [snd_w-1:0] adpcma_r;
    logic signed [snd_w-1:0] adpcmb_l;
    logic signed [snd_w-1:0] adpcmb_r;
    ch_t cur_ch;
    op_t cur_op;
    logic zero;
    logic signed [snd_w-1:0] left;
    logic signed [snd_w-1:0] right;

    // One hex digit per channel slot 0..5 (ch 0,1,2,4,5,6), rightmost is slot 0
    logic [23:0] tab_alg [n_rows] = '{24'h543210, 24'h765476, 24'h777777, 24'h777777,
                                      24'h777777, 24'h625704, 24'h543210, 24'h234567};
    logic [23:0] tab_rl [n_rows] = '{24'h333333, 24'h333333, 24'h213210, 24'h333333,
                                     24'h333333, 24'h303123, 24'h333333, 24'h033132};
    // Operator value = base + step * (slot * 4 + op), cut to 14 bits
    int tab_base [n_rows] = '{100, -200, 50, 8191, -8192, 333, 100, -77};
    int tab_step [n_rows] = '{7, 13, 3, 0, 0, -5, 7, 11};
    // ADPCM samples packed as {b_r, b_l, a_r, a_l}
    logic [63:0] tab_adpcm [n_rows] = '{64'h07d0_fed4_fc18_03e8, 64'h0050_ff00_0200_0100,
                                        64'h0123_0456_f789_0abc, 64'h7fff_7fff_7fff_7fff,
                                        64'h8000_8000_8000_8000, 64'h0010_fff0_0020_ffe0,
                                        64'h07d0_fed4_fc18_03e8, 64'hfc00_0400_0300_fd00};
    // Rows 6 and 7 run with pseudo-random clk_en
    logic [n_rows-1:0] rand_rows = 8'b1100_0000;

    // Expected outputs per frame, filled by the reference model
    int exp_l [n_rows];
    int exp_r [n_rows];
    int exp_l_now;
    int exp_r_now;
    int errors;
    int checks;
    int seed;
    int f;
    int p;
    int r;
    int last_p;
    bit ce;

    tb_clock_gen u_clk (.clk(clk));

    fm_mix_top #(.op_width(op_w), .snd_width(snd_w)) fm_mix_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .op_result (op_result),
        .alg       (alg),
        .rl        (rl),
        .adpcma_l  (adpcma_l),
        .adpcma_r  (adpcma_r),
        .adpcmb_l  (adpcmb_l),
        .adpcmb_r  (adpcmb_r),
        .cur_ch    (cur_ch),
        .cur_op    (cur_op),
        .zero      (zero),
        .left      (left),
        .right     (right)
    );

    function automatic int ch_code(int ci);
        return (ci < 3) ? ci : ci + 1;
    endfunction

    function automatic logic signed [op_w-1:0] op_value(int row, int ci, int op);
        int v;
        v = tab_base[row] + tab_step[row] * (ci * 4 + op);
        return v[op_w-1:0];
    endfunction

    // 0 a_l, 1 a_r, 2 b_l, 3 b_r
    function automatic logic signed [snd_w-1:0] adpcm_sample(int row, int idx);
        return tab_adpcm[row][16*idx +: 16];
    endfunction

    // Carrier set per algorithm, op 0 is the first operator
    function automatic bit is_carrier(int a, int op);
        case (a)
            4:       return (op == 1) || (op == 3);
            5, 6:    return op != 0;
            7:       return 1'b1;
            default: return op == 3;
        endcase
    endfunction

    function automatic int clamp16(int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    task automatic build_expected();
        int sl;
        int sr;
        int v;
        int ci;
        int op;
        logic [1:0] side;
        for (int row = 0; row < n_rows; row++) begin
            sl = 0;
            sr = 0;
            for (int slot = 0; slot < slots_per_frame; slot++) begin
                op = slot / 6;
                ci = slot % 6;
                side = tab_rl[row][4*ci +: 2];
                if (op == 0 && ch_code(ci) == int'(adpcma_ch)) begin
                    sl += int'(adpcm_sample(row, 0));
                    sr += int'(adpcm_sample(row, 1));
                end else if (op == 0 && ch_code(ci) == int'(adpcmb_ch)) begin
                    sl += int'(adpcm_sample(row, 2));
                    sr += int'(adpcm_sample(row, 3));
                end else if (is_carrier(int'(tab_alg[row][4*ci +: 3]), op)) begin
                    v = int'(op_value(row, ci, op));
                    if (side[1]) sl += v;
                    if (side[0]) sr += v;
                end
            end
            exp_l[row] = clamp16(sl);
            exp_r[row] = clamp16(sr);
        end
    endtask

    task automatic check_val(string name, int got, int expv);
        checks++;
        assert (got == expv) else begin
            errors++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, expv, $time);
        end
    endtask

    // Bounded by the worst clk_en pattern, four cycles per slot
    initial begin
        #((n_rows + 1) * slots_per_frame * 4 * 20 + 500);
        $display("Watchdog expired before all frames were applied");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        seed = 69363;
        errors = 0;
        checks = 0;
        exp_l_now = 0;
        exp_r_now = 0;
        rst_n = 1'b0;
        clk_en = 1'b0;
        op_result = '0;
        alg = '0;
        rl = '0;
        adpcma_l = '0;
        adpcma_r = '0;
        adpcmb_l = '0;
        adpcmb_r = '0;
        build_expected();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // Two extra slots at the end publish the last row and then show it
        for (f = 0; f <= n_rows; f++) begin
            r = (f < n_rows) ? f : 0;
            last_p = (f < n_rows) ? slots_per_frame - 1 : 1;
            for (p = 0; p <= last_p; p++) begin
                ce = 1'b0;
                while (!ce) begin
                    ce = rand_rows[r] ? (($random(seed) & 3) != 0) : 1'b1;
                    clk_en <= ce;
                    op_result <= op_value(r, p % 6, p / 6);
                    alg <= tab_alg[r][4*(p%6) +: 3];
                    rl <= tab_rl[r][4*(p%6) +: 2];
                    adpcma_l <= adpcm_sample(r, 0);
                    adpcma_r <= adpcm_sample(r, 1);
                    adpcmb_l <= adpcm_sample(r, 2);
                    adpcmb_r <= adpcm_sample(r, 3);
                    // Mid-cycle: slot indices and outputs are settled
                    @(negedge clk);
                    check_val("cur_ch", int'(cur_ch), ch_code(p % 6));
                    check_val("cur_op", int'(cur_op), p / 6);
                    check_val("zero", int'(zero), (p == 0) ? 1 : 0);
                    check_val("left", int'(left), exp_l_now);
                    check_val("right", int'(right), exp_r_now);
                    @(posedge clk);
                end
                // Frame boundary consumed, previous frame now published
                if (p == 0) begin
                    exp_l_now = (f == 0) ? 0 : exp_l[f-1];
                    exp_r_now = (f == 0) ? 0 : exp_r[f-1];
                end
            end
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
src/fm_mix_pkg.sv
src/fm_slot_counter.sv
src/fm_single_acc.sv
src/fm_mix_router.sv
src/fm_mix_top.sv
testbench/tb_clock_gen.sv
testbench/fm_mix_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the mixer testbench with Verilator, run it, and judge by its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fm_mix_tb \
    -f flist.f -Mdir obj_dir -o fm_mix_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/fm_mix_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
